//--- rtl/soc_cfg.svh
/* memory map, RAM geometry and pad-count defines for the
   peripheral subsystem */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// on-chip RAM depth in 32-bit words
`define SOC_RAM_WORDS 16384

// RAM region size in bytes, starting at address zero
`define SOC_RAM_BYTES (4 * `SOC_RAM_WORDS)

// word address width seen by the RAM macro
`define SOC_RAM_AW 14

// upper 24 address bits of the control register region
`define SOC_CTRL_BASE 24'h030000

// number of GPIO pads
`define SOC_GPIO_W 16

// pads come up as inputs
`define SOC_OEB_RST 16'hffff

`endif

//--- rtl/soc_pkg.sv
/* bus request/response structs, routing and register-offset enums,
   housekeeping inputs and pad configuration */
`include "soc_cfg.svh"

package soc_pkg;

  // native memory bus, master side
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // control region request after decode
  typedef struct packed {
    logic        sel;
    logic [7:0]  offset;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } ctrl_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } ctrl_rsp_t;

  typedef enum logic [7:0] {
    REG_GPIO_DATA = 8'h00,
    REG_GPIO_OEB  = 8'h04,
    REG_GPIO_PU   = 8'h08,
    REG_GPIO_PD   = 8'h0c,
    REG_HK_CONFIG = 8'h18,
    REG_HK_ENA    = 8'h1c,
    REG_HK_PLL    = 8'h20,
    REG_HK_MFGR   = 8'h24,
    REG_HK_PROD   = 8'h28,
    REG_HK_MASK   = 8'h2c,
    REG_CLK_SEL   = 8'h30,
    REG_XTAL_DEST = 8'h34,
    REG_PLL_DEST  = 8'h38,
    REG_TRAP_DEST = 8'h3c,
    REG_IRQ7_SRC  = 8'h40,
    REG_IRQ8_SRC  = 8'h44
  } reg_off_e;

  // destination of xtal, pll clock and trap
  typedef enum logic [1:0] {
    ROUTE_OFF,
    ROUTE_A,
    ROUTE_B,
    ROUTE_C
  } route_e;

  typedef enum logic [1:0] {
    IRQ_NONE,
    IRQ_PIN0,
    IRQ_PIN1,
    IRQ_PIN2
  } irq_src_e;

  // read-only words from housekeeping
  typedef struct packed {
    logic [7:0]  config_val;
    logic        xtal_ena;
    logic        reg_ena;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [3:0]  pll_trim;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
  } hk_ro_t;

  typedef struct packed {
    logic [`SOC_GPIO_W-1:0] gpio;
    logic [`SOC_GPIO_W-1:0] oeb;
    logic [`SOC_GPIO_W-1:0] pu;
    logic [`SOC_GPIO_W-1:0] pd;
    route_e                 xtal_dest;
    route_e                 pll_dest;
    route_e                 trap_dest;
    irq_src_e               irq7_src;
    irq_src_e               irq8_src;
  } pad_cfg_t;

endpackage

//--- rtl/soc_bus_decode.sv
/* region decode for RAM and control registers, RAM strobes with
   one-cycle ready, response merge */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_bus_decode
  import soc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_req_t               req_i,
  output mem_rsp_t               rsp_o,
  output ctrl_req_t              ctrl_req_o,
  input  ctrl_rsp_t              ctrl_rsp_i,
  output logic [3:0]             ram_wstrb_o,
  output logic [`SOC_RAM_AW-1:0] ram_addr_o,
  output logic [31:0]            ram_wdata_o,
  input  logic [31:0]            ram_rdata_i
);

  logic in_ram;
  logic in_ctrl;
  logic ram_range;
  logic ram_ready_q;
  logic ctrl_ready;
  logic bus_ready;

  assign in_ram  = req_i.addr < 32'(`SOC_RAM_BYTES);
  assign in_ctrl = req_i.addr[31:8] == `SOC_CTRL_BASE;

  // response from the register block counts only while it is addressed
  assign ctrl_ready = ctrl_req_o.sel && ctrl_rsp_i.ready;
  assign bus_ready  = ram_ready_q || ctrl_ready;

  // no new RAM access in the cycle that ends the current one
  assign ram_range = req_i.valid && !bus_ready && in_ram;

  assign ram_wstrb_o = ram_range ? req_i.wstrb : 4'h0;
  assign ram_addr_o  = req_i.addr[`SOC_RAM_AW+1:2];
  assign ram_wdata_o = req_i.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= ram_range;
    end
  end

  always_comb begin
    ctrl_req_o.sel    = req_i.valid && in_ctrl;
    ctrl_req_o.offset = req_i.addr[7:0];
    ctrl_req_o.wdata  = req_i.wdata;
    ctrl_req_o.wstrb  = req_i.wstrb;
  end

  // unmapped addresses simply never see ready
  always_comb begin
    rsp_o.ready = bus_ready;
    if (ctrl_ready) begin
      rsp_o.rdata = ctrl_rsp_i.rdata;
    end else if (ram_ready_q) begin
      rsp_o.rdata = ram_rdata_i;
    end else begin
      rsp_o.rdata = 32'h0;
    end
  end

endmodule

//--- rtl/sysctrl_regs.sv
/* system-control register file: GPIO data/enable/pulls, housekeeping
   readback, clock select, routing and irq source selects */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sysctrl_regs
  import soc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  ctrl_req_t              req_i,
  output ctrl_rsp_t              rsp_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_out_i,
  input  logic [`SOC_GPIO_W-1:0] gpio_in_i,
  input  hk_ro_t                 hk_i,
  input  logic                   clk_ext_sel_i,
  output pad_cfg_t               cfg_o
);

  pad_cfg_t    cfg_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_val;
  logic        access;
  logic        sel_we;
  reg_off_e    off;

  // byte-wise merge of a 16-bit register
  function automatic logic [15:0] merge16(input logic [15:0] old_v,
                                          input logic [31:0] wdata,
                                          input logic [3:0]  wstrb);
    logic [15:0] res;
    res = old_v;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  assign off    = reg_off_e'(req_i.offset);
  assign access = req_i.sel && !ready_q;
  assign sel_we = access && req_i.wstrb[0];

  always_comb begin
    case (off)
      REG_GPIO_DATA: rd_val = {gpio_out_i, gpio_in_i};
      REG_GPIO_OEB:  rd_val = {16'h0, cfg_q.oeb};
      REG_GPIO_PU:   rd_val = {16'h0, cfg_q.pu};
      REG_GPIO_PD:   rd_val = {16'h0, cfg_q.pd};
      REG_HK_CONFIG: rd_val = {24'h0, hk_i.config_val};
      REG_HK_ENA:    rd_val = {30'h0, hk_i.xtal_ena, hk_i.reg_ena};
      REG_HK_PLL: begin
        rd_val = {25'h0, hk_i.pll_trim, hk_i.pll_cp_ena, hk_i.pll_vco_ena,
                  hk_i.pll_bias_ena};
      end
      REG_HK_MFGR:   rd_val = {20'h0, hk_i.mfgr_id};
      REG_HK_PROD:   rd_val = {24'h0, hk_i.prod_id};
      REG_HK_MASK:   rd_val = {28'h0, hk_i.mask_rev};
      REG_CLK_SEL:   rd_val = {31'h0, clk_ext_sel_i};
      REG_XTAL_DEST: rd_val = {30'h0, cfg_q.xtal_dest};
      REG_PLL_DEST:  rd_val = {30'h0, cfg_q.pll_dest};
      REG_TRAP_DEST: rd_val = {30'h0, cfg_q.trap_dest};
      REG_IRQ7_SRC:  rd_val = {30'h0, cfg_q.irq7_src};
      REG_IRQ8_SRC:  rd_val = {30'h0, cfg_q.irq8_src};
      default:       rd_val = 32'h0;
    endcase
  end

  // ready pulses for one cycle, then drops while sel is still held
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_val;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.gpio      <= '0;
      cfg_q.oeb       <= `SOC_OEB_RST;
      cfg_q.pu        <= '0;
      cfg_q.pd        <= '0;
      cfg_q.xtal_dest <= ROUTE_OFF;
      cfg_q.pll_dest  <= ROUTE_OFF;
      cfg_q.trap_dest <= ROUTE_OFF;
      cfg_q.irq7_src  <= IRQ_NONE;
      cfg_q.irq8_src  <= IRQ_NONE;
    end else if (access) begin
      case (off)
        REG_GPIO_DATA: cfg_q.gpio <= merge16(cfg_q.gpio, req_i.wdata, req_i.wstrb);
        REG_GPIO_OEB:  cfg_q.oeb  <= merge16(cfg_q.oeb, req_i.wdata, req_i.wstrb);
        REG_GPIO_PU:   cfg_q.pu   <= merge16(cfg_q.pu, req_i.wdata, req_i.wstrb);
        REG_GPIO_PD:   cfg_q.pd   <= merge16(cfg_q.pd, req_i.wdata, req_i.wstrb);
        default: begin
          // 2-bit selectors only take byte 0
          if (sel_we) begin
            if (off == REG_XTAL_DEST) cfg_q.xtal_dest <= route_e'(req_i.wdata[1:0]);
            if (off == REG_PLL_DEST)  cfg_q.pll_dest  <= route_e'(req_i.wdata[1:0]);
            if (off == REG_TRAP_DEST) cfg_q.trap_dest <= route_e'(req_i.wdata[1:0]);
            if (off == REG_IRQ7_SRC)  cfg_q.irq7_src  <= irq_src_e'(req_i.wdata[1:0]);
            if (off == REG_IRQ8_SRC)  cfg_q.irq8_src  <= irq_src_e'(req_i.wdata[1:0]);
          end
        end
      endcase
    end
  end

  assign rsp_o.ready = ready_q;
  assign rsp_o.rdata = rdata_q;
  assign cfg_o       = cfg_q;

endmodule

//--- rtl/gpio_pad_mux.sv
/* pad multiplexer for xtal, pll clock, core clock and trap, with
   enable/pull overrides and irq pin selection */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module gpio_pad_mux
  import soc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   xtal_i,
  input  logic                   clk_pll_i,
  input  logic                   trap_i,
  input  pad_cfg_t               cfg_i,
  input  logic [`SOC_GPIO_W-1:0] gpio_in_i,
  output logic [`SOC_GPIO_W-1:0] gpio_out_o,
  output logic [`SOC_GPIO_W-1:0] gpio_outenb_o,
  output logic [`SOC_GPIO_W-1:0] gpio_pullupb_o,
  output logic [`SOC_GPIO_W-1:0] gpio_pulldownb_o,
  output logic                   irq7_o,
  output logic                   irq8_o
);

  logic [`SOC_GPIO_W-1:0] grp_mask;
  logic [`SOC_GPIO_W-1:0] xtal_hot;
  logic [`SOC_GPIO_W-1:0] trap_hot;
  logic [`SOC_GPIO_W-1:0] oeb;

  // three-pin group starting at lo, claimed by any active route
  function automatic logic [`SOC_GPIO_W-1:0] group(input route_e r, input int lo);
    logic [`SOC_GPIO_W-1:0] m;
    m = '0;
    if (r != ROUTE_OFF) begin
      m[lo +: 3] = 3'b111;
    end
    return m;
  endfunction

  // A, B, C pick pin lo, lo+1, lo+2
  function automatic logic [`SOC_GPIO_W-1:0] one_hot(input route_e r, input int lo);
    logic [`SOC_GPIO_W-1:0] m;
    m = '0;
    if (r != ROUTE_OFF) begin
      m[lo + int'(r) - 1] = 1'b1;
    end
    return m;
  endfunction

  assign grp_mask = group(cfg_i.xtal_dest, 5) | group(cfg_i.pll_dest, 8) |
                    group(cfg_i.trap_dest, 11);
  assign xtal_hot = one_hot(cfg_i.xtal_dest, 5);
  assign trap_hot = one_hot(cfg_i.trap_dest, 11);

  always_comb begin
    gpio_out_o = cfg_i.gpio;
    gpio_out_o = (gpio_out_o & ~xtal_hot) | (xtal_hot & {`SOC_GPIO_W{xtal_i}});
    gpio_out_o = (gpio_out_o & ~trap_hot) | (trap_hot & {`SOC_GPIO_W{trap_i}});
    // in the pll group A is the pll output, B the core clock and C only claims pins
    if (cfg_i.pll_dest == ROUTE_A) begin
      gpio_out_o[8] = clk_pll_i;
    end
    if (cfg_i.pll_dest == ROUTE_B) begin
      gpio_out_o[9] = clk_i;
    end
  end

  assign oeb              = cfg_i.oeb & ~grp_mask;
  assign gpio_outenb_o    = oeb | {`SOC_GPIO_W{~rst_n_i}};
  assign gpio_pullupb_o   = cfg_i.pu | grp_mask;
  assign gpio_pulldownb_o = cfg_i.pd | grp_mask;

  always_comb begin
    case (cfg_i.irq7_src)
      IRQ_PIN0: irq7_o = gpio_in_i[0];
      IRQ_PIN1: irq7_o = gpio_in_i[1];
      IRQ_PIN2: irq7_o = gpio_in_i[2];
      default:  irq7_o = 1'b0;
    endcase
    case (cfg_i.irq8_src)
      IRQ_PIN0: irq8_o = gpio_in_i[3];
      IRQ_PIN1: irq8_o = gpio_in_i[4];
      IRQ_PIN2: irq8_o = gpio_in_i[5];
      default:  irq8_o = 1'b0;
    endcase
  end

endmodule

//--- rtl/soc_periph_top.sv
/* peripheral subsystem top: bus decode, control registers, pad mux */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_periph_top
  import soc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   xtal_in_i,
  input  logic                   clk_pll_i,
  input  logic                   clk_ext_sel_i,
  input  logic                   trap_i,
  input  hk_ro_t                 hk_i,
  input  mem_req_t               mem_req_i,
  output mem_rsp_t               mem_rsp_o,
  output logic [3:0]             ram_wstrb_o,
  output logic [`SOC_RAM_AW-1:0] ram_addr_o,
  output logic [31:0]            ram_wdata_o,
  input  logic [31:0]            ram_rdata_i,
  output logic [`SOC_GPIO_W-1:0] gpio_out_o,
  output logic [`SOC_GPIO_W-1:0] gpio_outenb_o,
  output logic [`SOC_GPIO_W-1:0] gpio_pullupb_o,
  output logic [`SOC_GPIO_W-1:0] gpio_pulldownb_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_in_i,
  output logic                   irq7_o,
  output logic                   irq8_o
);

  ctrl_req_t ctrl_req;
  ctrl_rsp_t ctrl_rsp;
  pad_cfg_t  pad_cfg;

  soc_bus_decode u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (mem_req_i),
    .rsp_o      (mem_rsp_o),
    .ctrl_req_o (ctrl_req),
    .ctrl_rsp_i (ctrl_rsp),
    .ram_wstrb_o(ram_wstrb_o),
    .ram_addr_o (ram_addr_o),
    .ram_wdata_o(ram_wdata_o),
    .ram_rdata_i(ram_rdata_i)
  );

  // data register reads back the pads as driven
  sysctrl_regs u_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (ctrl_req),
    .rsp_o        (ctrl_rsp),
    .gpio_out_i   (gpio_out_o),
    .gpio_in_i    (gpio_in_i),
    .hk_i         (hk_i),
    .clk_ext_sel_i(clk_ext_sel_i),
    .cfg_o        (pad_cfg)
  );

  gpio_pad_mux u_pad_mux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .xtal_i          (xtal_in_i),
    .clk_pll_i       (clk_pll_i),
    .trap_i          (trap_i),
    .cfg_i           (pad_cfg),
    .gpio_in_i       (gpio_in_i),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq7_o          (irq7_o),
    .irq8_o          (irq8_o)
  );

endmodule

//--- tb/tb_ref.svh
/* xorshift source, reference models for pads, readback and irqs,
   compare tasks and the bus transfer task */
`ifndef TB_REF_SVH
`define TB_REF_SVH

function automatic logic [31:0] xorshift();
  logic [31:0] s;
  s = rng_state;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  rng_state = s;
  return s;
endfunction

// {out, oeb, pullup, pulldown} as the pads should show them
function automatic logic [63:0] ref_pads(input pad_cfg_t c, input logic xt,
                                         input logic pl, input logic tr,
                                         input logic clk, input logic in_rst);
  logic [15:0] o;
  logic [15:0] e;
  logic [15:0] u;
  logic [15:0] d;
  o = c.gpio;
  e = c.oeb;
  u = c.pu;
  d = c.pd;
  if (c.xtal_dest != ROUTE_OFF) begin
    o[4 + int'(c.xtal_dest)] = xt;
    e[7:5] = 3'b000;
    u[7:5] = 3'b111;
    d[7:5] = 3'b111;
  end
  if (c.pll_dest != ROUTE_OFF) begin
    if (c.pll_dest == ROUTE_A) o[8] = pl;
    if (c.pll_dest == ROUTE_B) o[9] = clk;
    e[10:8] = 3'b000;
    u[10:8] = 3'b111;
    d[10:8] = 3'b111;
  end
  if (c.trap_dest != ROUTE_OFF) begin
    o[10 + int'(c.trap_dest)] = tr;
    e[13:11] = 3'b000;
    u[13:11] = 3'b111;
    d[13:11] = 3'b111;
  end
  if (in_rst) e = 16'hffff;
  return {o, e, u, d};
endfunction

function automatic logic [31:0] ref_readback(input logic [7:0] off, input pad_cfg_t c,
                                             input hk_ro_t h, input logic cs,
                                             input logic [15:0] pout,
                                             input logic [15:0] pin);
  case (off)
    8'h00: return {pout, pin};
    8'h04: return {16'h0, c.oeb};
    8'h08: return {16'h0, c.pu};
    8'h0c: return {16'h0, c.pd};
    8'h18: return {24'h0, h.config_val};
    8'h1c: return {30'h0, h.xtal_ena, h.reg_ena};
    8'h20: return {25'h0, h.pll_trim, h.pll_cp_ena, h.pll_vco_ena, h.pll_bias_ena};
    8'h24: return {20'h0, h.mfgr_id};
    8'h28: return {24'h0, h.prod_id};
    8'h2c: return {28'h0, h.mask_rev};
    8'h30: return {31'h0, cs};
    8'h34: return {30'h0, c.xtal_dest};
    8'h38: return {30'h0, c.pll_dest};
    8'h3c: return {30'h0, c.trap_dest};
    8'h40: return {30'h0, c.irq7_src};
    8'h44: return {30'h0, c.irq8_src};
    default: return 32'h0;
  endcase
endfunction

// base is the first of the three candidate pins
function automatic logic ref_irq(input irq_src_e src, input logic [15:0] pin,
                                 input int base);
  if (src == IRQ_NONE) return 1'b0;
  return pin[base + int'(src) - 1];
endfunction

task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s.rdata got %h exp %h (ready %h)", name, got.rdata, exp.rdata,
             got.ready);
  end
endtask

task automatic check_pads(input string name, input logic [15:0] got, input logic [15:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s got %h exp %h", name, got, exp);
  end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s got %h exp %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s got %h exp %h", name, got, exp);
  end
endtask

// one transfer; the compare process checks the response against exp_rdata
task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] wstrb, input logic [31:0] exp_rdata);
  int  waited;
  logic ram_hit;
  ram_hit = addr < 32'h10000;
  @(posedge clk_i);
  #2;
  exp_rsp.ready = 1'b1;
  exp_rsp.rdata = exp_rdata;
  exp_pending = 1'b1;
  mem_req.valid = 1'b1;
  mem_req.addr  = addr;
  mem_req.wdata = wdata;
  mem_req.wstrb = wstrb;
  waited = 0;
  do begin
    @(negedge clk_i);
    waited++;
    if (waited == 1) begin
      check_word("ram_wstrb_o", {28'h0, ram_wstrb}, {28'h0, ram_hit ? wstrb : 4'h0});
      if (ram_hit) begin
        check_word("ram_addr_o", {18'h0, ram_addr}, {18'h0, addr[15:2]});
        check_word("ram_wdata_o", ram_wdata, wdata);
      end
    end
  end while (!mem_rsp.ready && waited < 20);
  checks++;
  if (!mem_rsp.ready) begin
    errors++;
    $display("no ready seen for address %h", addr);
  end else if (waited != 2) begin
    errors++;
    $display("ready for address %h came %0d cycles after the request", addr, waited - 1);
  end
  @(posedge clk_i);
  #2;
  mem_req.valid = 1'b0;
endtask

`endif

//--- tb/tb_top.sv
/* testbench for the peripheral subsystem: clock, reset, RAM model,
   timeout, compare process and test sequence */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_top
  import soc_pkg::*;
;

  logic        clk_i;
  logic        rst_n_i;
  logic        xtal_in;
  logic        clk_pll;
  logic        clk_ext_sel;
  logic        trap;
  hk_ro_t      hk;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic [3:0]  ram_wstrb;
  logic [13:0] ram_addr;
  logic [31:0] ram_wdata;
  logic [31:0] ram_rdata;
  logic [15:0] gpio_out;
  logic [15:0] gpio_outenb;
  logic [15:0] gpio_pullupb;
  logic [15:0] gpio_pulldownb;
  logic [15:0] gpio_in;
  logic        irq7;
  logic        irq8;

  logic [31:0] rng_state;
  logic [31:0] ram [16];
  logic [31:0] ref_ram [16];
  pad_cfg_t    model;
  mem_rsp_t    exp_rsp;
  logic        exp_pending;
  int          checks;
  int          errors;
  int          tests_ok;
  int          cycles;

  `include "tb_ref.svh"

  soc_periph_top dut0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .xtal_in_i       (xtal_in),
    .clk_pll_i       (clk_pll),
    .clk_ext_sel_i   (clk_ext_sel),
    .trap_i          (trap),
    .hk_i            (hk),
    .mem_req_i       (mem_req),
    .mem_rsp_o       (mem_rsp),
    .ram_wstrb_o     (ram_wstrb),
    .ram_addr_o      (ram_addr),
    .ram_wdata_o     (ram_wdata),
    .ram_rdata_i     (ram_rdata),
    .gpio_out_o      (gpio_out),
    .gpio_outenb_o   (gpio_outenb),
    .gpio_pullupb_o  (gpio_pullupb),
    .gpio_pulldownb_o(gpio_pulldownb),
    .gpio_in_i       (gpio_in),
    .irq7_o          (irq7),
    .irq8_o          (irq8)
  );

  always #10 clk_i = ~clk_i;

  // 16-word RAM, byte writes at the clock edge
  assign ram_rdata = ram[ram_addr[3:0]];

  always @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb[b]) ram[ram_addr[3:0]][8*b +: 8] <= ram_wdata[8*b +: 8];
    end
  end

  always @(negedge clk_i) begin
    if (mem_rsp.ready) begin
      if (!exp_pending) begin
        errors++;
        $display("ready seen with no request outstanding");
      end else begin
        check_rsp("mem_rsp_o", mem_rsp, exp_rsp);
      end
      exp_pending = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("timeout after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) tests_ok++;
    $display("test %-10s %s (%0d errors)", name, errors == err_before ? "ok" : "FAILED",
             errors - err_before);
  endtask

  task automatic check_all_pads(input logic in_rst);
    logic [63:0] p;
    p = ref_pads(model, xtal_in, clk_pll, trap, clk_i, in_rst);
    check_pads("gpio_out_o", gpio_out, p[63:48]);
    check_pads("gpio_outenb_o", gpio_outenb, p[47:32]);
    check_pads("gpio_pullupb_o", gpio_pullupb, p[31:16]);
    check_pads("gpio_pulldownb_o", gpio_pulldownb, p[15:0]);
  endtask

  function automatic logic [31:0] readback(input logic [7:0] off);
    logic [63:0] p;
    p = ref_pads(model, xtal_in, clk_pll, trap, 1'b0, 1'b0);
    return ref_readback(off, model, hk, clk_ext_sel, p[63:48], gpio_in);
  endfunction

  // register write through the bus, reference model updated after
  task automatic reg_write(input logic [7:0] off, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] old;
    old = readback(off);
    bus_xfer({24'h030000, off}, d, s, old);
    for (int b = 0; b < 2; b++) begin
      if (s[b]) begin
        if (off == 8'h00) model.gpio[8*b +: 8] = d[8*b +: 8];
        if (off == 8'h04) model.oeb[8*b +: 8] = d[8*b +: 8];
        if (off == 8'h08) model.pu[8*b +: 8] = d[8*b +: 8];
        if (off == 8'h0c) model.pd[8*b +: 8] = d[8*b +: 8];
      end
    end
    if (s[0]) begin
      if (off == 8'h34) model.xtal_dest = route_e'(d[1:0]);
      if (off == 8'h38) model.pll_dest = route_e'(d[1:0]);
      if (off == 8'h3c) model.trap_dest = route_e'(d[1:0]);
      if (off == 8'h40) model.irq7_src = irq_src_e'(d[1:0]);
      if (off == 8'h44) model.irq8_src = irq_src_e'(d[1:0]);
    end
  endtask

  initial begin
    int          e0;
    logic [3:0]  w;
    logic [3:0]  s;
    logic [31:0] d;
    logic [63:0] r64;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    xtal_in = 1'b0;
    clk_pll = 1'b0;
    clk_ext_sel = 1'b0;
    trap = 1'b0;
    hk = '0;
    mem_req = '0;
    gpio_in = 16'h0;
    rng_state = 32'h654ed8b8;
    exp_rsp = '0;
    exp_pending = 1'b0;
    checks = 0;
    errors = 0;
    tests_ok = 0;
    cycles = 0;
    for (int i = 0; i < 16; i++) begin
      ram[i] <= (i * 32'h11111111) ^ 32'h5a5a5a5a;
      ref_ram[i] = (i * 32'h11111111) ^ 32'h5a5a5a5a;
    end
    model = '0;
    model.oeb = 16'hffff;

    // reset state
    e0 = errors;
    repeat (8) @(negedge clk_i);
    check_all_pads(1'b1);
    check_bit("mem_rsp_o.ready", mem_rsp.ready, 1'b0);
    check_bit("irq7_o", irq7, 1'b0);
    check_bit("irq8_o", irq8, 1'b0);
    repeat (8) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_all_pads(1'b0);
    check_bit("mem_rsp_o.ready", mem_rsp.ready, 1'b0);
    check_bit("irq7_o", irq7, 1'b0);
    check_bit("irq8_o", irq8, 1'b0);
    end_test("reset", e0);

    // RAM writes then reads
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      w = 4'(xorshift());
      s = 4'(xorshift());
      d = xorshift();
      for (int b = 0; b < 4; b++) begin
        if (s[b]) ref_ram[w][8*b +: 8] = d[8*b +: 8];
      end
      bus_xfer({26'h0, w, 2'b00}, d, s, ref_ram[w]);
    end
    for (int i = 0; i < 16; i++) begin
      bus_xfer(32'(i * 4), 32'h0, 4'h0, ref_ram[i]);
    end
    end_test("ram", e0);

    // GPIO registers with byte strobes
    e0 = errors;
    @(posedge clk_i);
    #2 gpio_in = 16'(xorshift());
    for (int k = 0; k < 4; k++) begin
      reg_write(8'(k * 4), xorshift(), 4'(xorshift()));
      bus_xfer({24'h030000, 8'(k * 4)}, 32'h0, 4'h0, readback(8'(k * 4)));
    end
    end_test("gpio", e0);

    // housekeeping and clock select readback
    e0 = errors;
    @(posedge clk_i);
    #2;
    r64 = {xorshift(), xorshift()};
    hk = r64[$bits(hk_ro_t)-1:0];
    d = xorshift();
    clk_ext_sel = d[0];
    for (int a = 'h18; a <= 'h30; a += 4) begin
      bus_xfer({24'h030000, 8'(a)}, 32'h0, 4'h0, readback(8'(a)));
    end
    end_test("hk", e0);

    // xtal and trap routing onto pads
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      reg_write(8'h34, 32'(i), 4'h1);
      reg_write(8'h3c, 32'(3 - i), 4'h1);
      for (int j = 0; j < 2; j++) begin
        @(posedge clk_i);
        #2;
        d = xorshift();
        xtal_in = d[0];
        trap = d[1];
        @(negedge clk_i);
        check_all_pads(1'b0);
      end
    end
    end_test("routing", e0);

    // irq source selection
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      reg_write(8'h40, 32'(i), 4'h1);
      reg_write(8'h44, 32'(3 - i), 4'h1);
      for (int j = 0; j < 3; j++) begin
        @(posedge clk_i);
        #2 gpio_in = 16'(xorshift());
        @(negedge clk_i);
        check_bit("irq7_o", irq7, ref_irq(model.irq7_src, gpio_in, 0));
        check_bit("irq8_o", irq8, ref_irq(model.irq8_src, gpio_in, 3));
      end
    end
    end_test("irq", e0);

    $display("%0d checks, %0d errors, %0d of 6 tests passed", checks, errors, tests_ok);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+rtl
+incdir+tb
rtl/soc_pkg.sv
rtl/soc_bus_decode.sv
rtl/sysctrl_regs.sv
rtl/gpio_pad_mux.sv
rtl/soc_periph_top.sv
tb/tb_top.sv

//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+') tb/tb_ref.svh rtl/soc_cfg.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
